/* tsc_cpu.f */
src/tsc_pkg.sv
src/alu.sv
src/register_file.sv
src/control.sv
src/forwarding_unit.sv
src/btb.sv
src/cpu.sv
test/tb_memory.sv
test/tb_cpu.sv

/* test/tb_cpu.sv */
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import tsc_pkg::*;

	localparam int HALT_TIMEOUT = 2000;
	localparam int GOLDEN_STEPS = 5000;

	logic Clk;
	logic rst_n;
	logic [WORD_W-1:0] imem_data;
	logic [WORD_W-1:0] dmem_rdata;
	logic [WORD_W-1:0] imem_addr;
	logic imem_read;
	dmem_req_t dmem_req;
	wwd_t wwd;
	logic [WORD_W-1:0] num_inst;
	logic is_halted;

	int errors;
	int checks;
	int build_pc;
	int unsigned seed;
	logic collecting;
	logic [WORD_W-1:0] got_wwd [$];
	logic [WORD_W-1:0] got_waddr [$];
	logic [WORD_W-1:0] got_wdata [$];
	logic [WORD_W-1:0] exp_wwd [$];
	logic [WORD_W-1:0] exp_waddr [$];
	logic [WORD_W-1:0] exp_wdata [$];
	int exp_count;

	cpu i_cpu (
		.Clk(Clk),
		.rst_n(rst_n),
		.imem_data(imem_data),
		.dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr),
		.imem_read(imem_read),
		.dmem_req(dmem_req),
		.wwd(wwd),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	tb_memory mem_model (
		.Clk(Clk),
		.imem_addr(imem_addr),
		.imem_read(imem_read),
		.dmem_req(dmem_req),
		.imem_data(imem_data),
		.dmem_rdata(dmem_rdata)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Outputs are settled mid-cycle
	always @(negedge Clk) begin
		if (collecting) begin
			if (wwd.valid) begin
				got_wwd.push_back(wwd.value);
			end
			if (dmem_req.write) begin
				got_waddr.push_back(dmem_req.addr);
				got_wdata.push_back(dmem_req.wdata);
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	function automatic logic [WORD_W-1:0] itype(input logic [3:0] op, input int rs,
			input int rt, input int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic logic [WORD_W-1:0] rtype(input logic [5:0] fn, input int rs,
			input int rt, input int rd);
		return {OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	function automatic logic [WORD_W-1:0] jtype(input logic [3:0] op, input int target);
		return {op, target[11:0]};
	endfunction

	task automatic new_program();
		mem_model.clear();
		build_pc = 0;
	endtask

	task automatic emit(input logic [WORD_W-1:0] word);
		mem_model.write_instr(build_pc, word);
		build_pc++;
	endtask

	// Offset is relative to the word after the branch
	task automatic emit_branch(input logic [3:0] op, input int rs, input int rt, input int target);
		emit(itype(op, rs, rt, target - (build_pc + 1)));
	endtask

	// Sequential ISA model over the loaded memories
	task automatic golden_run();
		logic [WORD_W-1:0] regs [NUM_REGS];
		logic [WORD_W-1:0] dmem [256];
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] instr;
		logic [WORD_W-1:0] simm;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] next_pc;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic done;
		int steps;
		exp_wwd.delete();
		exp_waddr.delete();
		exp_wdata.delete();
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = mem_model.read_data(16'(i));
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < GOLDEN_STEPS) begin
			instr = mem_model.read_instr(pc);
			rs = instr[11:10];
			rt = instr[9:8];
			rd = instr[7:6];
			simm = {{8{instr[7]}}, instr[7:0]};
			addr = regs[rs] + simm;
			next_pc = pc + 16'd1;
			steps++;
			case (instr[15:12])
				OP_BNE: if (regs[rs] != regs[rt]) next_pc = pc + 16'd1 + simm;
				OP_BEQ: if (regs[rs] == regs[rt]) next_pc = pc + 16'd1 + simm;
				OP_BGZ: if ($signed(regs[rs]) > 0) next_pc = pc + 16'd1 + simm;
				OP_BLZ: if ($signed(regs[rs]) < 0) next_pc = pc + 16'd1 + simm;
				OP_ADI: regs[rt] = regs[rs] + simm;
				OP_ORI: regs[rt] = regs[rs] | {8'h00, instr[7:0]};
				OP_LHI: regs[rt] = {instr[7:0], 8'h00};
				OP_LWD: regs[rt] = dmem[addr[7:0]];
				OP_SWD: begin
					dmem[addr[7:0]] = regs[rt];
					exp_waddr.push_back(addr);
					exp_wdata.push_back(regs[rt]);
				end
				OP_JMP: next_pc = {next_pc[15:12], instr[11:0]};
				OP_JAL: begin
					regs[2] = pc + 16'd1;
					next_pc = {next_pc[15:12], instr[11:0]};
				end
				OP_RTYPE: begin
					case (instr[5:0])
						FN_ADD: regs[rd] = regs[rs] + regs[rt];
						FN_SUB: regs[rd] = regs[rs] - regs[rt];
						FN_AND: regs[rd] = regs[rs] & regs[rt];
						FN_ORR: regs[rd] = regs[rs] | regs[rt];
						FN_NOT: regs[rd] = ~regs[rs];
						FN_TCP: regs[rd] = 16'd0 - regs[rs];
						FN_SHL: regs[rd] = {regs[rs][14:0], 1'b0};
						FN_SHR: regs[rd] = {regs[rs][15], regs[rs][15:1]};
						FN_JPR: next_pc = regs[rs];
						FN_JRL: begin
							next_pc = regs[rs];
							regs[2] = pc + 16'd1;
						end
						FN_WWD: exp_wwd.push_back(regs[rs]);
						FN_HLT: done = 1'b1;
						default: begin
							errors++;
							$display("Golden model found an unknown function code at 0x%0h", pc);
							done = 1'b1;
						end
					endcase
				end
				default: begin
					errors++;
					$display("Golden model found an unknown opcode at 0x%0h", pc);
					done = 1'b1;
				end
			endcase
			pc = next_pc;
		end
		exp_count = steps;
		if (!done) begin
			errors++;
			$display("Golden model never reached HLT");
		end
	endtask

	task automatic reset_core();
		collecting = 1'b0;
		@(posedge Clk);
		#1 rst_n = 1'b0;
		repeat (2) @(posedge Clk);
		#1 rst_n = 1'b1;
		got_wwd.delete();
		got_waddr.delete();
		got_wdata.delete();
		collecting = 1'b1;
	endtask

	task automatic run_program(input string name);
		int cycles;
		int wwd_at_halt;
		logic [WORD_W-1:0] count_at_halt;
		golden_run();
		reset_core();
		cycles = 0;
		while (!is_halted && cycles < HALT_TIMEOUT) begin
			@(negedge Clk);
			cycles++;
		end
		if (!is_halted) begin
			errors++;
			$display("%s: CPU did not halt within %0d cycles", name, HALT_TIMEOUT);
		end else begin
			// HLT sits in execute here, so no strobe is pending
			wwd_at_halt = got_wwd.size();
			// Let older instructions drain before sampling
			repeat (5) @(negedge Clk);
			count_at_halt = num_inst;
			repeat (20) @(negedge Clk);
			check({name, " wwd strobes after halt"}, got_wwd.size(), wwd_at_halt);
			check({name, " num_inst held"}, num_inst, count_at_halt);
			check({name, " num_inst"}, num_inst, exp_count);
		end
		collecting = 1'b0;
		check({name, " wwd count"}, got_wwd.size(), exp_wwd.size());
		for (int i = 0; i < exp_wwd.size() && i < got_wwd.size(); i++) begin
			check($sformatf("%s wwd.value[%0d]", name, i), got_wwd[i], exp_wwd[i]);
		end
		check({name, " store count"}, got_waddr.size(), exp_waddr.size());
		for (int i = 0; i < exp_waddr.size() && i < got_waddr.size(); i++) begin
			check($sformatf("%s dmem_req.addr[%0d]", name, i), got_waddr[i], exp_waddr[i]);
			check($sformatf("%s dmem_req.wdata[%0d]", name, i), got_wdata[i], exp_wdata[i]);
		end
	endtask

	task automatic idle_outputs(input string when);
		check({when, " imem_read"}, imem_read, 0);
		check({when, " dmem_req.read"}, dmem_req.read, 0);
		check({when, " dmem_req.write"}, dmem_req.write, 0);
		check({when, " wwd.valid"}, wwd.valid, 0);
		check({when, " is_halted"}, is_halted, 0);
		check({when, " imem_addr"}, imem_addr, 0);
		check({when, " num_inst"}, num_inst, 0);
	endtask

	task automatic check_reset_state();
		new_program();
		@(posedge Clk);
		#1 rst_n = 1'b0;
		@(posedge Clk);
		@(negedge Clk);
		idle_outputs("during reset");
		@(posedge Clk);
		#1 rst_n = 1'b1;
		@(negedge Clk);
		idle_outputs("after reset");
	endtask

	task automatic alu_chain();
		new_program();
		emit(itype(OP_ADI, 0, 1, 5));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(itype(OP_ADI, 1, 2, -3));
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(rtype(FN_ADD, 1, 2, 3));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(rtype(FN_SUB, 3, 1, 0));
		emit(rtype(FN_WWD, 0, 0, 0));
		emit(rtype(FN_AND, 3, 0, 1));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(rtype(FN_ORR, 1, 3, 2));
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(rtype(FN_NOT, 2, 0, 3));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(rtype(FN_TCP, 3, 0, 0));
		emit(rtype(FN_WWD, 0, 0, 0));
		emit(rtype(FN_SHL, 3, 0, 1));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(rtype(FN_SHR, 1, 0, 2));
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(itype(OP_ORI, 2, 3, 'hA5));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(itype(OP_LHI, 0, 0, 'h9C));
		emit(rtype(FN_WWD, 0, 0, 0));
		// Two results forwarded at once
		emit(rtype(FN_SHR, 0, 0, 1));
		emit(rtype(FN_ADD, 1, 0, 2));
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(rtype(FN_HLT, 0, 0, 0));
		run_program("alu_chain");
	endtask

	task automatic load_store();
		new_program();
		emit(itype(OP_ADI, 0, 1, 16));
		emit(itype(OP_ADI, 0, 2, 'h55));
		emit(itype(OP_SWD, 1, 2, 0));
		emit(itype(OP_SWD, 1, 1, 1));
		emit(itype(OP_LWD, 1, 3, 0));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(itype(OP_LWD, 1, 0, 3));
		emit(rtype(FN_ADD, 0, 1, 3));
		emit(rtype(FN_WWD, 3, 0, 0));
		// Loaded value is the store data
		emit(itype(OP_LWD, 1, 2, -2));
		emit(itype(OP_SWD, 1, 2, 4));
		emit(itype(OP_LWD, 1, 3, 4));
		emit(rtype(FN_WWD, 3, 0, 0));
		// Loaded value is the next address
		emit(itype(OP_LWD, 1, 1, 1));
		emit(itype(OP_LWD, 1, 0, 0));
		emit(rtype(FN_WWD, 0, 0, 0));
		emit(rtype(FN_HLT, 0, 0, 0));
		run_program("load_store");
	endtask

	task automatic branch_cases();
		int loop_top;
		new_program();
		emit(itype(OP_ADI, 0, 1, 5));
		// Loop exit fetches the store at the top on the wrong path
		loop_top = build_pc;
		emit(itype(OP_SWD, 1, 3, 32));
		emit(itype(OP_ADI, 3, 3, 3));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(itype(OP_ADI, 1, 1, -1));
		emit_branch(OP_BNE, 1, 0, loop_top);
		emit_branch(OP_BEQ, 1, 0, build_pc + 2);
		emit(rtype(FN_WWD, 3, 0, 0));
		emit_branch(OP_BEQ, 3, 0, build_pc + 2);
		emit(itype(OP_ADI, 3, 3, 1));
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(itype(OP_ADI, 0, 2, -4));
		emit_branch(OP_BGZ, 2, 0, build_pc + 2);
		emit(rtype(FN_WWD, 2, 0, 0));
		emit_branch(OP_BLZ, 2, 0, build_pc + 2);
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(itype(OP_ADI, 2, 2, 11));
		emit_branch(OP_BGZ, 2, 0, build_pc + 2);
		emit(rtype(FN_WWD, 0, 0, 0));
		emit_branch(OP_BLZ, 2, 0, build_pc + 2);
		emit(rtype(FN_WWD, 2, 0, 0));
		// Zero is not greater than zero
		emit_branch(OP_BGZ, 0, 0, build_pc + 2);
		emit(rtype(FN_WWD, 3, 0, 0));
		emit(rtype(FN_HLT, 0, 0, 0));
		run_program("branch_cases");
	endtask

	task automatic jump_link();
		new_program();
		emit(itype(OP_ADI, 0, 1, 12));
		emit(jtype(OP_JMP, 3));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(jtype(OP_JAL, 6));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(rtype(FN_WWD, 1, 0, 0));
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(rtype(FN_JPR, 1, 0, 0));
		emit(rtype(FN_WWD, 2, 0, 0));
		build_pc = 12;
		emit(itype(OP_ADI, 0, 3, 20));
		emit(rtype(FN_JRL, 3, 0, 0));
		emit(rtype(FN_WWD, 3, 0, 0));
		build_pc = 20;
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(jtype(OP_JAL, 30));
		emit(rtype(FN_WWD, 3, 0, 0));
		build_pc = 30;
		emit(rtype(FN_WWD, 2, 0, 0));
		emit(rtype(FN_HLT, 0, 0, 0));
		// Sits in decode behind HLT and never strobes
		emit(rtype(FN_WWD, 2, 0, 0));
		run_program("jump_link");
	endtask

	task automatic random_alu();
		int kind;
		int rs;
		int rt;
		int rd;
		logic [5:0] fn;
		new_program();
		for (int i = 0; i < 40; i++) begin
			kind = $urandom % 5;
			rs = $urandom % 4;
			rt = $urandom % 4;
			rd = $urandom % 4;
			if (kind == 0) begin
				emit(itype(OP_ADI, rs, rt, $urandom % 256));
				emit(rtype(FN_WWD, rt, 0, 0));
			end else begin
				case (kind)
					1: fn = FN_ADD;
					2: fn = FN_SUB;
					3: fn = FN_AND;
					default: fn = FN_ORR;
				endcase
				emit(rtype(fn, rs, rt, rd));
				emit(rtype(FN_WWD, rd, 0, 0));
			end
		end
		emit(rtype(FN_HLT, 0, 0, 0));
		run_program("random_alu");
	endtask

	initial begin
		errors = 0;
		checks = 0;
		build_pc = 0;
		collecting = 1'b0;
		rst_n = 1'b0;
		seed = 63521;
		seed = $urandom(seed);
		mem_model.clear();

		check_reset_state();
		alu_chain();
		load_store();
		branch_cases();
		jump_link();
		random_alu();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_memory.sv */
`default_nettype none

module tb_memory (
	input wire logic Clk,
	input wire logic [tsc_pkg::WORD_W-1:0] imem_addr,
	input wire logic imem_read,
	input wire tsc_pkg::dmem_req_t dmem_req,
	output logic [tsc_pkg::WORD_W-1:0] imem_data,
	output logic [tsc_pkg::WORD_W-1:0] dmem_rdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import tsc_pkg::*;

	localparam int DEPTH = 256;

	logic [WORD_W-1:0] imem [DEPTH];
	logic [WORD_W-1:0] dmem [DEPTH];

	assign imem_data = imem_read ? imem[imem_addr[7:0]] : '0;
	assign dmem_rdata = dmem[dmem_req.addr[7:0]];

	always @(posedge Clk) begin
		if (dmem_req.write) begin
			dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
		end
	end

	function automatic logic [WORD_W-1:0] data_fill(input int addr);
		return (16'(addr) * 16'h0107) ^ 16'h5A3C;
	endfunction

	task automatic clear();
		for (int i = 0; i < DEPTH; i++) begin
			// Unused words decode as HLT
			imem[i] = {OP_RTYPE, 6'(i) ^ 6'(i >> 6), FN_HLT};
			dmem[i] = data_fill(i);
		end
	endtask

	task automatic write_instr(input int addr, input logic [WORD_W-1:0] word);
		imem[addr[7:0]] = word;
	endtask

	function automatic logic [WORD_W-1:0] read_instr(input logic [WORD_W-1:0] addr);
		return imem[addr[7:0]];
	endfunction

	function automatic logic [WORD_W-1:0] read_data(input logic [WORD_W-1:0] addr);
		return dmem[addr[7:0]];
	endfunction

endmodule

`default_nettype wire

/* src/cpu.sv */
`default_nettype none

module cpu (
	input wire logic Clk,
	input wire logic rst_n,
	input wire logic [tsc_pkg::WORD_W-1:0] imem_data,
	input wire logic [tsc_pkg::WORD_W-1:0] dmem_rdata,
	output logic [tsc_pkg::WORD_W-1:0] imem_addr,
	output logic imem_read,
	output tsc_pkg::dmem_req_t dmem_req,
	output tsc_pkg::wwd_t wwd,
	output logic [tsc_pkg::WORD_W-1:0] num_inst,
	output logic is_halted
);
	import tsc_pkg::*;

	typedef struct packed {
		logic valid;
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] pred_pc;
		logic [WORD_W-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] pred_pc;
		logic [WORD_W-1:0] instr;
		logic [WORD_W-1:0] rs_data;
		logic [WORD_W-1:0] rt_data;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [REG_ADDR_W-1:0] dest;
		logic [WORD_W-1:0] alu_result;
		logic [WORD_W-1:0] store_data;
		logic [WORD_W-1:0] link;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [REG_ADDR_W-1:0] dest;
		logic [WORD_W-1:0] alu_result;
		logic [WORD_W-1:0] mem_data;
		logic [WORD_W-1:0] link;
	} mem_wb_t;

	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] pred_pc;
	logic fetch_en;
	logic halted_q;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	ctrl_t dec_ctrl;
	logic [WORD_W-1:0] rf_rs_data;
	logic [WORD_W-1:0] rf_rt_data;
	logic load_use;
	logic dec_flush;

	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	logic [WORD_W-1:0] rs_val;
	logic [WORD_W-1:0] rt_val;
	logic [WORD_W-1:0] alu_a;
	logic [WORD_W-1:0] alu_b;
	logic [WORD_W-1:0] alu_c;
	logic [WORD_W-1:0] ex_imm_s;
	logic [WORD_W-1:0] ex_pc_plus1;
	logic [WORD_W-1:0] jump_target;
	logic [WORD_W-1:0] ex_next_pc;
	logic [REG_ADDR_W-1:0] ex_dest;
	logic br_cond;
	logic br_taken;
	logic redirect;
	logic mispredict;
	logic ex_halt;
	logic halt;

	logic [WORD_W-1:0] mem_fwd;
	logic [WORD_W-1:0] wb_data;

	function automatic logic [WORD_W-1:0] operand(input logic [1:0] sel,
			input logic [WORD_W-1:0] rf_val);
		case (sel)
			FWD_MEM: return mem_fwd;
			FWD_WB: return wb_data;
			default: return rf_val;
		endcase
	endfunction

	btb i_btb (
		.Clk(Clk),
		.rst_n(rst_n),
		.fetch_pc(pc),
		.upd_en(id_ex.valid && redirect),
		.upd_pc(id_ex.pc),
		.upd_target(ex_next_pc),
		.pred_pc(pred_pc)
	);

	assign imem_addr = pc;
	assign imem_read = fetch_en && !halt;

	// Decode
	assign load_use = if_id.valid && id_ex.ctrl.mem_read
		&& (ex_dest == if_id.instr[11:10] || ex_dest == if_id.instr[9:8]);
	assign dec_flush = mispredict || load_use || halt;

	control i_control (
		.instr(if_id.instr),
		.flush(dec_flush || !if_id.valid),
		.ctrl(dec_ctrl)
	);

	register_file i_register_file (
		.Clk(Clk),
		.rst_n(rst_n),
		.rs_addr(if_id.instr[11:10]),
		.rt_addr(if_id.instr[9:8]),
		.wr_addr(mem_wb.dest),
		.wr_en(mem_wb.ctrl.reg_write),
		.wr_data(wb_data),
		.rs_data(rf_rs_data),
		.rt_data(rf_rt_data)
	);

	// Execute
	forwarding_unit i_forwarding_unit (
		.ex_rs(id_ex.instr[11:10]),
		.ex_rt(id_ex.instr[9:8]),
		.mem_dest(ex_mem.dest),
		.mem_reg_write(ex_mem.ctrl.reg_write),
		.wb_dest(mem_wb.dest),
		.wb_reg_write(mem_wb.ctrl.reg_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	assign rs_val = operand(fwd_a, id_ex.rs_data);
	assign rt_val = operand(fwd_b, id_ex.rt_data);
	assign ex_imm_s = {{(WORD_W-8){id_ex.instr[7]}}, id_ex.instr[7:0]};
	assign ex_pc_plus1 = id_ex.pc + WORD_W'(1);
	assign jump_target = {ex_pc_plus1[WORD_W-1:12], id_ex.instr[11:0]};
	assign alu_a = (id_ex.ctrl.alu_src == SRC_UIMM) ? '0 : rs_val;

	always_comb begin
		case (id_ex.ctrl.alu_src)
			SRC_SIMM: alu_b = ex_imm_s;
			SRC_ZIMM: alu_b = {{(WORD_W-8){1'b0}}, id_ex.instr[7:0]};
			SRC_UIMM: alu_b = {id_ex.instr[7:0], {(WORD_W-8){1'b0}}};
			default: alu_b = rt_val;
		endcase
		case (id_ex.ctrl.reg_dest)
			DEST_RT: ex_dest = id_ex.instr[9:8];
			DEST_LINK: ex_dest = LINK_REG;
			default: ex_dest = id_ex.instr[7:6];
		endcase
	end

	alu i_alu (
		.a(alu_a),
		.b(alu_b),
		.op(id_ex.ctrl.alu_op),
		.c(alu_c)
	);

	always_comb begin
		case (id_ex.instr[15:12])
			OP_BNE: br_cond = (rs_val != rt_val);
			OP_BEQ: br_cond = (rs_val == rt_val);
			OP_BGZ: br_cond = !rs_val[WORD_W-1] && (rs_val != '0);
			OP_BLZ: br_cond = rs_val[WORD_W-1];
			default: br_cond = 1'b0;
		endcase
		br_taken = id_ex.ctrl.branch && br_cond;
		redirect = id_ex.ctrl.jtype_jump || id_ex.ctrl.rtype_jump || br_taken;
		if (id_ex.ctrl.jtype_jump) begin
			ex_next_pc = jump_target;
		end else if (id_ex.ctrl.rtype_jump) begin
			ex_next_pc = rs_val;
		end else if (br_taken) begin
			ex_next_pc = ex_pc_plus1 + ex_imm_s;
		end else begin
			ex_next_pc = ex_pc_plus1;
		end
	end

	// Covers both a missed taken branch and a wrong BTB hit
	assign mispredict = id_ex.valid && (ex_next_pc != id_ex.pred_pc);
	assign ex_halt = id_ex.valid && id_ex.ctrl.is_halt;
	assign halt = ex_halt || halted_q;
	assign is_halted = halt;

	assign wwd.valid = id_ex.valid && id_ex.ctrl.is_wwd;
	assign wwd.value = rs_val;

	// Memory and writeback
	assign dmem_req.read = ex_mem.ctrl.mem_read;
	assign dmem_req.write = ex_mem.ctrl.mem_write;
	assign dmem_req.addr = ex_mem.alu_result;
	assign dmem_req.wdata = ex_mem.store_data;

	assign mem_fwd = ex_mem.ctrl.pc_to_reg ? ex_mem.link : ex_mem.alu_result;
	assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.mem_data
		: mem_wb.ctrl.pc_to_reg ? mem_wb.link : mem_wb.alu_result;

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= '0;
			fetch_en <= 1'b0;
			halted_q <= 1'b0;
			if_id.valid <= 1'b0;
			id_ex.valid <= 1'b0;
			id_ex.ctrl <= '0;
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl <= '0;
			mem_wb.valid <= 1'b0;
			mem_wb.ctrl <= '0;
		end else begin
			fetch_en <= 1'b1;
			if (ex_halt) begin
				halted_q <= 1'b1;
			end

			if (!halt) begin
				if (mispredict) begin
					pc <= ex_next_pc;
				end else if (fetch_en && !load_use) begin
					pc <= pred_pc;
				end
			end

			if (mispredict || halt) begin
				if_id.valid <= 1'b0;
			end else if (!load_use) begin
				if_id.valid <= fetch_en;
				if_id.pc <= pc;
				if_id.pred_pc <= pred_pc;
				if_id.instr <= imem_data;
			end

			id_ex.valid <= if_id.valid && !dec_flush;
			id_ex.ctrl <= dec_ctrl;
			id_ex.pc <= if_id.pc;
			id_ex.pred_pc <= if_id.pred_pc;
			id_ex.instr <= if_id.instr;
			id_ex.rs_data <= rf_rs_data;
			id_ex.rt_data <= rf_rt_data;

			ex_mem.valid <= id_ex.valid;
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.dest <= ex_dest;
			ex_mem.alu_result <= alu_c;
			ex_mem.store_data <= rt_val;
			ex_mem.link <= ex_pc_plus1;

			mem_wb.valid <= ex_mem.valid;
			mem_wb.ctrl <= ex_mem.ctrl;
			mem_wb.dest <= ex_mem.dest;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.mem_data <= dmem_rdata;
			mem_wb.link <= ex_mem.link;
		end
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			num_inst <= '0;
		end else if (mem_wb.valid) begin
			num_inst <= num_inst + WORD_W'(1);
		end
	end

endmodule

`default_nettype wire

/* src/btb.sv */
`default_nettype none

module btb (
	input wire logic Clk,
	input wire logic rst_n,
	input wire logic [tsc_pkg::WORD_W-1:0] fetch_pc,
	input wire logic upd_en,
	input wire logic [tsc_pkg::WORD_W-1:0] upd_pc,
	input wire logic [tsc_pkg::WORD_W-1:0] upd_target,
	output logic [tsc_pkg::WORD_W-1:0] pred_pc
);
	import tsc_pkg::*;

	logic [BTB_ENTRIES-1:0] valid;
	logic [BTB_TAG_W-1:0] tag [BTB_ENTRIES];
	logic [WORD_W-1:0] target [BTB_ENTRIES];

	logic [BTB_INDEX_W-1:0] rd_idx;
	logic [BTB_INDEX_W-1:0] wr_idx;
	logic hit;

	assign rd_idx = fetch_pc[BTB_INDEX_W-1:0];
	assign wr_idx = upd_pc[BTB_INDEX_W-1:0];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (upd_en) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (upd_en) begin
			tag[wr_idx] <= upd_pc[WORD_W-1:BTB_INDEX_W];
			target[wr_idx] <= upd_target;
		end
	end

	assign hit = valid[rd_idx] && (tag[rd_idx] == fetch_pc[WORD_W-1:BTB_INDEX_W]);

	// Miss falls through to the next word
	assign pred_pc = hit ? target[rd_idx] : fetch_pc + WORD_W'(1);

endmodule

`default_nettype wire

/* src/forwarding_unit.sv */
`default_nettype none

module forwarding_unit (
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] ex_rs,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] ex_rt,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] mem_dest,
	input wire logic mem_reg_write,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] wb_dest,
	input wire logic wb_reg_write,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b
);
	import tsc_pkg::*;

	// Memory stage holds the younger result, so it wins
	function automatic logic [1:0] pick(input logic [REG_ADDR_W-1:0] src);
		if (mem_reg_write && mem_dest == src) begin
			return FWD_MEM;
		end else if (wb_reg_write && wb_dest == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign fwd_a = pick(ex_rs);
	assign fwd_b = pick(ex_rt);

endmodule

`default_nettype wire

/* src/control.sv */
`default_nettype none

module control (
	input wire logic [tsc_pkg::WORD_W-1:0] instr,
	input wire logic flush,
	output tsc_pkg::ctrl_t ctrl
);
	import tsc_pkg::*;

	logic [3:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[15:12];
	assign funct = instr[5:0];

	function automatic ctrl_t rtype_alu(input alu_op_e op);
		ctrl_t c;
		c = '0;
		c.alu_op = op;
		c.alu_src = SRC_REG;
		c.reg_dest = DEST_RD;
		c.reg_write = 1'b1;
		return c;
	endfunction

	always_comb begin
		ctrl = '0;
		if (!flush) begin
			case (opcode)
				OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
					ctrl.branch = 1'b1;
				end
				OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
					ctrl.reg_dest = DEST_RT;
					ctrl.reg_write = 1'b1;
					ctrl.alu_src = SRC_SIMM;
					if (opcode == OP_ORI) begin
						ctrl.alu_op = ALU_ORR;
						ctrl.alu_src = SRC_ZIMM;
					end
					// LHI adds the shifted immediate to zero
					if (opcode == OP_LHI) begin
						ctrl.alu_src = SRC_UIMM;
					end
					if (opcode == OP_LWD) begin
						ctrl.mem_read = 1'b1;
						ctrl.mem_to_reg = 1'b1;
					end
				end
				OP_SWD: begin
					ctrl.alu_src = SRC_SIMM;
					ctrl.mem_write = 1'b1;
				end
				OP_JMP, OP_JAL: begin
					ctrl.jtype_jump = 1'b1;
					if (opcode == OP_JAL) begin
						ctrl.reg_dest = DEST_LINK;
						ctrl.reg_write = 1'b1;
						ctrl.pc_to_reg = 1'b1;
					end
				end
				OP_RTYPE: begin
					case (funct)
						FN_ADD: ctrl = rtype_alu(ALU_ADD);
						FN_SUB: ctrl = rtype_alu(ALU_SUB);
						FN_AND: ctrl = rtype_alu(ALU_AND);
						FN_ORR: ctrl = rtype_alu(ALU_ORR);
						FN_NOT: ctrl = rtype_alu(ALU_NOT);
						FN_TCP: ctrl = rtype_alu(ALU_TCP);
						FN_SHL: ctrl = rtype_alu(ALU_SHL);
						FN_SHR: ctrl = rtype_alu(ALU_SHR);
						FN_JPR: ctrl.rtype_jump = 1'b1;
						FN_JRL: begin
							ctrl.rtype_jump = 1'b1;
							ctrl.reg_dest = DEST_LINK;
							ctrl.reg_write = 1'b1;
							ctrl.pc_to_reg = 1'b1;
						end
						FN_WWD: ctrl.is_wwd = 1'b1;
						FN_HLT: ctrl.is_halt = 1'b1;
						default: ctrl = '0;
					endcase
				end
				default: ctrl = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/register_file.sv */
`default_nettype none

module register_file (
	input wire logic Clk,
	input wire logic rst_n,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] rs_addr,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] rt_addr,
	input wire logic [tsc_pkg::REG_ADDR_W-1:0] wr_addr,
	input wire logic wr_en,
	input wire logic [tsc_pkg::WORD_W-1:0] wr_data,
	output logic [tsc_pkg::WORD_W-1:0] rs_data,
	output logic [tsc_pkg::WORD_W-1:0] rt_data
);
	import tsc_pkg::*;

	logic [WORD_W-1:0] regs [NUM_REGS];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Writeback value bypasses to decode in the same cycle
	assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
	input wire logic [tsc_pkg::WORD_W-1:0] a,
	input wire logic [tsc_pkg::WORD_W-1:0] b,
	input wire tsc_pkg::alu_op_e op,
	output logic [tsc_pkg::WORD_W-1:0] c
);
	import tsc_pkg::*;

	always_comb begin
		unique case (op)
			ALU_ADD: c = a + b;
			ALU_SUB: c = a - b;
			ALU_AND: c = a & b;
			ALU_ORR: c = a | b;
			ALU_NOT: c = ~a;
			ALU_TCP: c = ~a + WORD_W'(1);
			ALU_SHL: c = a << 1;
			// Arithmetic shift keeps the sign bit
			ALU_SHR: c = $signed(a) >>> 1;
		endcase
	end

endmodule

`default_nettype wire

/* src/tsc_pkg.sv */
`default_nettype none

package tsc_pkg;

	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 2;
	localparam int NUM_REGS = 1 << REG_ADDR_W;
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 2'd2;

	localparam int BTB_INDEX_W = 3;
	localparam int BTB_ENTRIES = 1 << BTB_INDEX_W;
	localparam int BTB_TAG_W = WORD_W - BTB_INDEX_W;

	// Opcode field in instr[15:12]
	localparam logic [3:0] OP_BNE = 4'd0;
	localparam logic [3:0] OP_BEQ = 4'd1;
	localparam logic [3:0] OP_BGZ = 4'd2;
	localparam logic [3:0] OP_BLZ = 4'd3;
	localparam logic [3:0] OP_ADI = 4'd4;
	localparam logic [3:0] OP_ORI = 4'd5;
	localparam logic [3:0] OP_LHI = 4'd6;
	localparam logic [3:0] OP_LWD = 4'd7;
	localparam logic [3:0] OP_SWD = 4'd8;
	localparam logic [3:0] OP_JMP = 4'd9;
	localparam logic [3:0] OP_JAL = 4'd10;
	localparam logic [3:0] OP_RTYPE = 4'd15;

	// R-type function field in instr[5:0]
	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_AND = 6'd2;
	localparam logic [5:0] FN_ORR = 6'd3;
	localparam logic [5:0] FN_NOT = 6'd4;
	localparam logic [5:0] FN_TCP = 6'd5;
	localparam logic [5:0] FN_SHL = 6'd6;
	localparam logic [5:0] FN_SHR = 6'd7;
	localparam logic [5:0] FN_JPR = 6'd25;
	localparam logic [5:0] FN_JRL = 6'd26;
	localparam logic [5:0] FN_WWD = 6'd28;
	localparam logic [5:0] FN_HLT = 6'd29;

	// Operand source selects for execute
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_WB = 2'd1;
	localparam logic [1:0] FWD_MEM = 2'd2;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
	} alu_op_e;

	typedef enum logic [1:0] {SRC_REG, SRC_SIMM, SRC_ZIMM, SRC_UIMM} alu_src_e;

	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} reg_dest_e;

	typedef struct packed {
		alu_op_e alu_op;
		alu_src_e alu_src;
		reg_dest_e reg_dest;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic pc_to_reg;
		logic branch;
		logic jtype_jump;
		logic rtype_jump;
		logic is_wwd;
		logic is_halt;
	} ctrl_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic valid;
		logic [WORD_W-1:0] value;
	} wwd_t;

endpackage

`default_nettype wire
